/* Makefile */
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Some tests failed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/compute_core.sv */
`timescale 1ns/100ps
`default_nettype none

module compute_core import simt_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  warp_count_t          num_warps,
    output logic                 done,
    output logic [MAX_WARPS-1:0] imem_valid,
    output pc_t                  imem_address [MAX_WARPS],
    input  logic [MAX_WARPS-1:0] imem_ready,
    input  instr_t               imem_data [MAX_WARPS],
    output port_mask_t           dmem_write_valid,
    output word_t                dmem_write_address [NUM_PORTS],
    output word_t                dmem_write_data [NUM_PORTS],
    input  port_mask_t           dmem_write_ready
);

    logic [MAX_WARPS-1:0] fetch_start;
    logic [MAX_WARPS-1:0] fetch_done;
    pc_t                  pc [MAX_WARPS];
    instr_t               fetched [MAX_WARPS];
    warp_idx_t            issue_warp;
    logic                 decode_load;
    logic                 execute;
    logic                 store_start;
    logic                 store_busy;

    opcode_e   op;
    logic      is_scalar;
    logic      reg_write;
    logic      is_branch;
    logic      is_store;
    logic      is_sync;
    logic      is_halt;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     imm;

    word_t      sc_rs1;
    word_t      sc_rs2;
    word_t      sc_result;
    lane_vec_t  vec_rs1;
    lane_vec_t  vec_rs2;
    lane_vec_t  lane_result;
    port_mask_t port_enable;
    word_t      store_addr [NUM_PORTS];
    word_t      store_data [NUM_PORTS];

    for (genvar w = 0; w < MAX_WARPS; w++) begin : g_fetch
        warp_fetcher u_fetcher (
            .clk(clk), .reset(reset), .fetch_start(fetch_start[w]), .pc(pc[w]),
            .imem_ready(imem_ready[w]), .imem_data(imem_data[w]),
            .imem_valid(imem_valid[w]), .imem_address(imem_address[w]),
            .fetch_done(fetch_done[w]), .instruction(fetched[w])
        );
    end

    instr_decoder u_decoder (
        .clk(clk), .reset(reset), .decode_load(decode_load),
        .instruction(fetched[issue_warp]), .op(op), .is_scalar(is_scalar),
        .reg_write(reg_write), .is_branch(is_branch), .is_store(is_store),
        .is_sync(is_sync), .is_halt(is_halt), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm)
    );

    warp_scheduler u_scheduler (
        .clk(clk), .reset(reset), .start(start), .num_warps(num_warps),
        .fetch_done(fetch_done), .is_branch(is_branch), .is_store(is_store),
        .is_sync(is_sync), .is_halt(is_halt), .imm(imm), .branch_taken(|sc_rs1),
        .store_busy(store_busy), .fetch_start(fetch_start), .pc(pc),
        .issue_warp(issue_warp), .decode_load(decode_load), .execute(execute),
        .store_start(store_start), .done(done)
    );

    // Scalar flag picks which bank takes the result
    reg_bank #(.payload_t(word_t)) u_scalar_bank (
        .clk(clk), .reset(reset), .warp(issue_warp),
        .write_enable(execute && reg_write && is_scalar), .rd(rd),
        .write_data(sc_result), .rs1(rs1), .rs2(rs2),
        .rs1_data(sc_rs1), .rs2_data(sc_rs2)
    );

    reg_bank #(.payload_t(lane_vec_t)) u_vector_bank (
        .clk(clk), .reset(reset), .warp(issue_warp),
        .write_enable(execute && reg_write && !is_scalar), .rd(rd),
        .write_data(lane_result), .rs1(rs1), .rs2(rs2),
        .rs1_data(vec_rs1), .rs2_data(vec_rs2)
    );

    // Scalar TID yields the warp index
    lane_alu u_scalar_alu (
        .op(op), .a(sc_rs1), .b(sc_rs2), .imm(imm),
        .tid(word_t'(issue_warp)), .result(sc_result)
    );

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        lane_alu u_alu (
            .op(op), .a((op == OP_BCAST) ? sc_rs1 : vec_rs1[l]), .b(vec_rs2[l]),
            .imm(imm), .tid(word_t'(int'(issue_warp) * NUM_LANES + l)),
            .result(lane_result[l])
        );
        assign store_addr[l] = lane_result[l];
        assign store_data[l] = vec_rs2[l];
    end

    assign store_addr[SCALAR_PORT] = sc_result;
    assign store_data[SCALAR_PORT] = sc_rs2;
    assign port_enable = is_scalar ? port_mask_t'(1) << SCALAR_PORT
                                   : port_mask_t'({NUM_LANES{1'b1}});

    store_unit u_store (
        .clk(clk), .reset(reset), .store_start(store_start), .port_enable(port_enable),
        .address(store_addr), .data(store_data), .dmem_write_ready(dmem_write_ready),
        .dmem_write_valid(dmem_write_valid), .dmem_write_address(dmem_write_address),
        .dmem_write_data(dmem_write_data), .store_busy(store_busy)
    );

endmodule

`default_nettype wire

/* hdl/instr_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module instr_decoder import simt_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      decode_load,
    input  instr_t    instruction,
    output opcode_e   op,
    output logic      is_scalar,
    output logic      reg_write,
    output logic      is_branch,
    output logic      is_store,
    output logic      is_sync,
    output logic      is_halt,
    output reg_addr_t rd,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output word_t     imm
);

    opcode_e op_in;

    assign op_in = opcode_e'(instruction[31:28]);

    // Class flags
    always_ff @(posedge clk) begin
        if (reset) begin
            op        <= OP_NOP;
            is_scalar <= 1'b0;
            reg_write <= 1'b0;
            is_branch <= 1'b0;
            is_store  <= 1'b0;
            is_sync   <= 1'b0;
            is_halt   <= 1'b0;
        end else if (decode_load) begin
            op        <= op_in;
            is_scalar <= instruction[27];
            reg_write <= op_in inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                       OP_ADDI, OP_LDI, OP_TID, OP_BCAST};
            is_branch <= (op_in == OP_BNEZ);
            is_store  <= (op_in == OP_STORE);
            is_sync   <= (op_in == OP_SYNC);
            is_halt   <= (op_in == OP_HALT);
        end
    end

    // Operand fields
    always_ff @(posedge clk) begin
        if (decode_load) begin
            rd  <= instruction[26:23];
            rs1 <= instruction[22:19];
            rs2 <= instruction[18:15];
            imm <= {{(WORD_W-IMM_W){instruction[IMM_W-1]}}, instruction[IMM_W-1:0]};
        end
    end

endmodule

`default_nettype wire

/* hdl/lane_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module lane_alu import simt_pkg::*; (
    input  opcode_e op,
    input  word_t   a,
    input  word_t   b,
    input  word_t   imm,
    input  word_t   tid,
    output word_t   result
);

    always_comb begin
        case (op)
            OP_ADD:   result = a + b;
            OP_SUB:   result = a - b;
            OP_AND:   result = a & b;
            OP_OR:    result = a | b;
            OP_XOR:   result = a ^ b;
            OP_ADDI:  result = a + imm;
            OP_LDI:   result = imm;
            OP_TID:   result = tid;
            // Caller routes the scalar source onto a
            OP_BCAST: result = a;
            // Store address
            OP_STORE: result = a + imm;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/reg_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_bank import simt_pkg::*; #(
    parameter type payload_t = word_t
) (
    input  logic      clk,
    input  logic      reset,
    input  warp_idx_t warp,
    input  logic      write_enable,
    input  reg_addr_t rd,
    input  payload_t  write_data,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output payload_t  rs1_data,
    output payload_t  rs2_data
);

    // One register set per warp slot
    payload_t regs [MAX_WARPS][NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (write_enable) begin
            regs[warp][rd] <= write_data;
        end
    end

    assign rs1_data = regs[warp][rs1];
    assign rs2_data = regs[warp][rs2];

endmodule

`default_nettype wire

/* hdl/simt_pkg.sv */
`default_nettype none

package simt_pkg;

    // Core dimensions
    localparam int MAX_WARPS   = 4;
    localparam int NUM_LANES   = 4;
    localparam int NUM_PORTS   = NUM_LANES + 1;
    localparam int SCALAR_PORT = NUM_LANES;
    localparam int NUM_REGS    = 16;
    localparam int WORD_W      = 32;
    localparam int PC_W        = 8;
    localparam int IMM_W       = 15;

    typedef logic [WORD_W-1:0]             word_t;
    typedef logic [PC_W-1:0]               pc_t;
    typedef logic [31:0]                   instr_t;
    typedef logic [$clog2(NUM_REGS)-1:0]   reg_addr_t;
    typedef logic [$clog2(MAX_WARPS)-1:0]  warp_idx_t;
    typedef logic [$clog2(MAX_WARPS):0]    warp_count_t;
    typedef logic [NUM_PORTS-1:0]          port_mask_t;

    // Lane 0 sits in the low word
    typedef logic [NUM_LANES-1:0][WORD_W-1:0] lane_vec_t;

    // Instruction bits 31:28
    typedef enum logic [3:0] {
        OP_NOP   = 4'h0,
        OP_ADD   = 4'h1,
        OP_SUB   = 4'h2,
        OP_AND   = 4'h3,
        OP_OR    = 4'h4,
        OP_XOR   = 4'h5,
        OP_ADDI  = 4'h6,
        OP_LDI   = 4'h7,
        OP_TID   = 4'h8,
        OP_BCAST = 4'h9,
        OP_BNEZ  = 4'hA,
        OP_STORE = 4'hB,
        OP_SYNC  = 4'hC,
        OP_HALT  = 4'hD
    } opcode_e;

    typedef enum logic [2:0] {
        WARP_IDLE,
        WARP_FETCH,
        WARP_DECODE,
        WARP_EXECUTE,
        WARP_STORE_WAIT,
        WARP_SYNC_WAIT,
        WARP_UPDATE,
        WARP_DONE
    } warp_state_e;

endpackage

`default_nettype wire

/* hdl/store_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module store_unit import simt_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       store_start,
    input  port_mask_t port_enable,
    input  word_t      address [NUM_PORTS],
    input  word_t      data [NUM_PORTS],
    input  port_mask_t dmem_write_ready,
    output port_mask_t dmem_write_valid,
    output word_t      dmem_write_address [NUM_PORTS],
    output word_t      dmem_write_data [NUM_PORTS],
    output logic       store_busy
);

    assign store_busy = store_start || (|dmem_write_valid);

    // Pending flags, one per port
    always_ff @(posedge clk) begin
        if (reset) begin
            dmem_write_valid <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (dmem_write_valid[p] && dmem_write_ready[p]) begin
                    dmem_write_valid[p] <= 1'b0;
                end else if (store_start && port_enable[p]) begin
                    dmem_write_valid[p] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (store_start && port_enable[p]) begin
                dmem_write_address[p] <= address[p];
                dmem_write_data[p]    <= data[p];
            end
        end
    end

    // No new store may land on a port that is still stalled
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_hold_check
        a_hold: assert property (@(posedge clk) disable iff (reset)
            dmem_write_valid[p] && !dmem_write_ready[p] |=>
                dmem_write_valid[p] && $stable(dmem_write_address[p])
                && $stable(dmem_write_data[p]));
    end

endmodule

`default_nettype wire

/* hdl/warp_fetcher.sv */
`timescale 1ns/100ps
`default_nettype none

module warp_fetcher import simt_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   fetch_start,
    input  pc_t    pc,
    input  logic   imem_ready,
    input  instr_t imem_data,
    output logic   imem_valid,
    output pc_t    imem_address,
    output logic   fetch_done,
    output instr_t instruction
);

    logic accepted;

    assign accepted = imem_valid && imem_ready;

    // Valid doubles as the requesting state
    always_ff @(posedge clk) begin
        if (reset) begin
            imem_valid <= 1'b0;
            fetch_done <= 1'b0;
        end else begin
            fetch_done <= accepted;
            if (accepted) begin
                imem_valid <= 1'b0;
            end else if (fetch_start) begin
                imem_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_start) begin
            imem_address <= pc;
        end
        if (accepted) begin
            instruction <= imem_data;
        end
    end

    // Request must not move or vanish while memory stalls
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        imem_valid && !imem_ready |=> imem_valid && $stable(imem_address));

endmodule

`default_nettype wire

/* hdl/warp_scheduler.sv */
`timescale 1ns/100ps
`default_nettype none

module warp_scheduler import simt_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  warp_count_t          num_warps,
    input  logic [MAX_WARPS-1:0] fetch_done,
    input  logic                 is_branch,
    input  logic                 is_store,
    input  logic                 is_sync,
    input  logic                 is_halt,
    input  word_t                imm,
    input  logic                 branch_taken,
    input  logic                 store_busy,
    output logic [MAX_WARPS-1:0] fetch_start,
    output pc_t                  pc [MAX_WARPS],
    output warp_idx_t            issue_warp,
    output logic                 decode_load,
    output logic                 execute,
    output logic                 store_start,
    output logic                 done
);

    warp_state_e          state [MAX_WARPS];
    logic [MAX_WARPS-1:0] fetched;
    logic [MAX_WARPS-1:0] holds_slot;
    logic [MAX_WARPS-1:0] in_update;
    logic                 running;
    logic                 slot_busy;
    logic                 grant_found;
    warp_idx_t            grant_warp;
    logic                 all_sync;
    logic                 all_quiet;

    always_comb begin
        all_sync  = 1'b1;
        all_quiet = 1'b1;
        for (int w = 0; w < MAX_WARPS; w++) begin
            holds_slot[w] = state[w] inside {WARP_DECODE, WARP_EXECUTE, WARP_STORE_WAIT};
            in_update[w]  = (state[w] == WARP_UPDATE);
            if (!(state[w] inside {WARP_IDLE, WARP_DONE, WARP_SYNC_WAIT})) begin
                all_sync = 1'b0;
            end
            if (!(state[w] inside {WARP_IDLE, WARP_DONE})) begin
                all_quiet = 1'b0;
            end
        end
        slot_busy = |holds_slot || |in_update;
    end

    // Round robin, starting after the last issuer
    always_comb begin
        warp_idx_t cand;
        grant_found = 1'b0;
        grant_warp  = issue_warp;
        for (int k = 1; k <= MAX_WARPS; k++) begin
            cand = issue_warp + warp_idx_t'(k);
            if (!grant_found && state[cand] == WARP_FETCH && fetched[cand]) begin
                grant_found = 1'b1;
                grant_warp  = cand;
            end
        end
    end

    assign decode_load = (state[issue_warp] == WARP_DECODE);
    assign execute     = (state[issue_warp] == WARP_EXECUTE);
    assign store_start = execute && is_store;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < MAX_WARPS; w++) begin
                state[w] <= WARP_IDLE;
                pc[w]    <= '0;
            end
            fetched     <= '0;
            fetch_start <= '0;
            issue_warp  <= warp_idx_t'(MAX_WARPS - 1);
            running     <= 1'b0;
            done        <= 1'b0;
        end else begin
            fetch_start <= '0;
            if (start && !running && !done) begin
                running <= 1'b1;
                for (int w = 0; w < MAX_WARPS; w++) begin
                    if (w < int'(num_warps)) begin
                        state[w]       <= WARP_FETCH;
                        pc[w]          <= '0;
                        fetched[w]     <= 1'b0;
                        fetch_start[w] <= 1'b1;
                    end
                end
            end else begin
                if (!slot_busy && grant_found) begin
                    issue_warp <= grant_warp;
                end
                for (int w = 0; w < MAX_WARPS; w++) begin
                    case (state[w])
                        WARP_FETCH: begin
                            if (!slot_busy && grant_found && grant_warp == warp_idx_t'(w)) begin
                                state[w]   <= WARP_DECODE;
                                fetched[w] <= 1'b0;
                            end else if (fetch_done[w]) begin
                                fetched[w] <= 1'b1;
                            end
                        end
                        WARP_DECODE: state[w] <= WARP_EXECUTE;
                        WARP_EXECUTE: begin
                            pc[w] <= (is_branch && branch_taken) ? pc[w] + pc_t'(imm)
                                                                 : pc[w] + pc_t'(1);
                            if (is_halt) begin
                                state[w] <= WARP_DONE;
                            end else if (is_sync) begin
                                state[w] <= WARP_SYNC_WAIT;
                            end else if (is_store) begin
                                state[w] <= WARP_STORE_WAIT;
                            end else begin
                                state[w] <= WARP_UPDATE;
                            end
                        end
                        WARP_STORE_WAIT: begin
                            if (!store_busy) begin
                                state[w] <= WARP_UPDATE;
                            end
                        end
                        // Barrier opens for every waiting warp at once
                        WARP_SYNC_WAIT: begin
                            if (all_sync) begin
                                state[w] <= WARP_UPDATE;
                            end
                        end
                        WARP_UPDATE: begin
                            state[w]       <= WARP_FETCH;
                            fetch_start[w] <= 1'b1;
                        end
                        default: ;
                    endcase
                end
                if (running && all_quiet) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // Issue slot is exclusive across all warp FSMs
    a_one_issuer: assert property (@(posedge clk) disable iff (reset) $onehot0(holds_slot));

    a_done_sticky: assert property (@(posedge clk) disable iff (reset) done |=> done);

endmodule

`default_nettype wire

/* tb/core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module core_tb import simt_pkg::*; ();

    // Data regions written by the program
    localparam int VEC_BASE    = 'h100;
    localparam int SCALAR_BASE = 'h200;
    localparam int SYNC_BASE   = 'h300;
    localparam int LOOP_COUNT  = 3;
    // Two runs, four warps, about 25 instructions of up to 20 cycles, margin of 5
    localparam int TIMEOUT_CYCLES = 2 * MAX_WARPS * 25 * 20 * 5;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 start;
    warp_count_t          num_warps;
    logic                 done;
    logic [MAX_WARPS-1:0] imem_valid;
    pc_t                  imem_address [MAX_WARPS];
    logic [MAX_WARPS-1:0] imem_ready;
    instr_t               imem_data [MAX_WARPS];
    port_mask_t           dmem_write_valid;
    word_t                dmem_write_address [NUM_PORTS];
    word_t                dmem_write_data [NUM_PORTS];
    port_mask_t           dmem_write_ready;

    instr_t program_image [2**PC_W];

    // Expected writes, keyed by address
    word_t exp_data [word_t];
    int    exp_port [word_t];
    bit    seen [word_t];
    int    pre_sync_expected;
    int    pre_sync_seen;
    int    last_count [MAX_WARPS];

    int errors         = 0;
    int writes_checked = 0;
    int cycles         = 0;

    logic                 prev_reset = 1'b0;
    logic                 prev_done;
    logic [MAX_WARPS-1:0] imem_stall;
    pc_t                  imem_addr_hold [MAX_WARPS];
    port_mask_t           dmem_stall;
    word_t                dmem_addr_hold [NUM_PORTS];
    word_t                dmem_data_hold [NUM_PORTS];

    always #2 clk = ~clk;

    compute_core dut0 (
        .clk(clk), .reset(reset), .start(start), .num_warps(num_warps), .done(done),
        .imem_valid(imem_valid), .imem_address(imem_address),
        .imem_ready(imem_ready), .imem_data(imem_data),
        .dmem_write_valid(dmem_write_valid), .dmem_write_address(dmem_write_address),
        .dmem_write_data(dmem_write_data), .dmem_write_ready(dmem_write_ready)
    );

    tb_memory memory0 (
        .clk(clk), .reset(reset), .program_image(program_image),
        .imem_valid(imem_valid), .imem_address(imem_address),
        .imem_ready(imem_ready), .imem_data(imem_data),
        .dmem_write_valid(dmem_write_valid), .dmem_write_ready(dmem_write_ready)
    );

    function automatic instr_t encode(input opcode_e op, input int scalar, input int rd,
                                      input int rs1, input int rs2, input int imm);
        return {op, 1'(scalar), reg_addr_t'(rd), reg_addr_t'(rs1), reg_addr_t'(rs2),
                imm[IMM_W-1:0]};
    endfunction

    task automatic flag_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic load_program();
        for (int a = 0; a < 2**PC_W; a++) begin
            program_image[a] = '0;
        end
        // v1 = tid, v2 = 3 * tid + 100
        program_image[0]  = encode(OP_TID,   0, 1, 0, 0, 0);
        program_image[1]  = encode(OP_ADD,   0, 2, 1, 1, 0);
        program_image[2]  = encode(OP_ADD,   0, 2, 2, 1, 0);
        program_image[3]  = encode(OP_ADDI,  0, 2, 2, 0, 100);
        program_image[4]  = encode(OP_STORE, 0, 0, 1, 2, VEC_BASE);
        // s1 counts down, s3 = warp * 4
        program_image[5]  = encode(OP_LDI,   1, 1, 0, 0, LOOP_COUNT);
        program_image[6]  = encode(OP_TID,   1, 2, 0, 0, 0);
        program_image[7]  = encode(OP_ADD,   1, 3, 2, 2, 0);
        program_image[8]  = encode(OP_ADD,   1, 3, 3, 3, 0);
        program_image[9]  = encode(OP_ADD,   1, 4, 3, 1, 0);
        program_image[10] = encode(OP_STORE, 1, 0, 4, 1, SCALAR_BASE);
        program_image[11] = encode(OP_ADDI,  1, 1, 1, 0, -1);
        program_image[12] = encode(OP_BNEZ,  1, 0, 1, 0, -3);
        program_image[13] = encode(OP_SYNC,  0, 0, 0, 0, 0);
        program_image[14] = encode(OP_STORE, 0, 0, 1, 1, SYNC_BASE);
        program_image[15] = encode(OP_HALT,  0, 0, 0, 0, 0);
    endtask

    task automatic expect_writes(input int n);
        int tid;
        exp_data.delete();
        exp_port.delete();
        for (int w = 0; w < n; w++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                tid = w * NUM_LANES + l;
                exp_data[word_t'(VEC_BASE + tid)]  = word_t'(3 * tid + 100);
                exp_port[word_t'(VEC_BASE + tid)]  = l;
                exp_data[word_t'(SYNC_BASE + tid)] = word_t'(tid);
                exp_port[word_t'(SYNC_BASE + tid)] = l;
            end
            // Counter value stored before each decrement
            for (int c = 1; c <= LOOP_COUNT; c++) begin
                exp_data[word_t'(SCALAR_BASE + w * 4 + c)] = word_t'(c);
                exp_port[word_t'(SCALAR_BASE + w * 4 + c)] = SCALAR_PORT;
            end
        end
        pre_sync_expected = n * (NUM_LANES + LOOP_COUNT);
    endtask

    task automatic check_write(input int p);
        word_t addr;
        word_t data;
        int    w;
        int    c;
        addr = dmem_write_address[p];
        data = dmem_write_data[p];
        w    = (int'(addr) - SCALAR_BASE) / 4;
        c    = (int'(addr) - SCALAR_BASE) % 4;
        writes_checked++;
        assert (!done) else flag_error($sformatf("write to 0x%0h accepted after done", addr));
        assert (exp_data.exists(addr))
            else flag_error($sformatf("unexpected write to 0x%0h on port %0d", addr, p));
        if (exp_data.exists(addr)) begin
            assert (!seen.exists(addr))
                else flag_error($sformatf("second write to 0x%0h", addr));
            assert (exp_port[addr] == p)
                else flag_error($sformatf("write to 0x%0h on port %0d, expected port %0d",
                                          addr, p, exp_port[addr]));
            assert (data == exp_data[addr])
                else flag_error($sformatf("write to 0x%0h carried 0x%0h, expected 0x%0h",
                                          addr, data, exp_data[addr]));
            seen[addr] = 1'b1;
            // Nothing past the barrier before every earlier write
            if (addr >= word_t'(SYNC_BASE)) begin
                assert (pre_sync_seen == pre_sync_expected)
                    else flag_error($sformatf("write to 0x%0h after only %0d of %0d pre-sync writes",
                                              addr, pre_sync_seen, pre_sync_expected));
            end else begin
                pre_sync_seen++;
            end
            if (addr >= word_t'(SCALAR_BASE) && addr < word_t'(SYNC_BASE)) begin
                assert (c < last_count[w])
                    else flag_error($sformatf("warp %0d stored count %0d after %0d",
                                              w, c, last_count[w]));
                last_count[w] = c;
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            if (prev_reset) begin
                assert (!done && imem_valid == '0 && dmem_write_valid == '0)
                    else flag_error("done or a valid is high during reset");
            end
            seen.delete();
            pre_sync_seen = 0;
            for (int w = 0; w < MAX_WARPS; w++) begin
                last_count[w] = LOOP_COUNT + 1;
            end
            prev_done  <= 1'b0;
            imem_stall <= '0;
            dmem_stall <= '0;
        end else begin
            if (prev_done) begin
                assert (done) else flag_error("done fell without a reset");
            end
            if (done) begin
                assert (imem_valid == '0) else flag_error("instruction fetch after done");
            end
            if (done && !prev_done) begin
                assert (seen.num() == exp_data.num())
                    else flag_error($sformatf("done rose after %0d of %0d expected writes",
                                              seen.num(), exp_data.num()));
            end
            for (int w = 0; w < MAX_WARPS; w++) begin
                if (imem_stall[w]) begin
                    assert (imem_valid[w] && imem_address[w] == imem_addr_hold[w])
                        else flag_error($sformatf("warp %0d fetch changed while stalled", w));
                end
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (dmem_stall[p]) begin
                    assert (dmem_write_valid[p] && dmem_write_address[p] == dmem_addr_hold[p]
                            && dmem_write_data[p] == dmem_data_hold[p])
                        else flag_error($sformatf("port %0d write changed while stalled", p));
                end
                if (dmem_write_valid[p] && dmem_write_ready[p]) begin
                    check_write(p);
                end
            end
            prev_done      <= done;
            imem_stall     <= imem_valid & ~imem_ready;
            imem_addr_hold <= imem_address;
            dmem_stall     <= dmem_write_valid & ~dmem_write_ready;
            dmem_addr_hold <= dmem_write_address;
            dmem_data_hold <= dmem_write_data;
        end
        prev_reset <= reset;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the core did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic run_program(input int n);
        reset     <= 1'b1;
        start     <= 1'b0;
        num_warps <= warp_count_t'(n);
        expect_writes(n);
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (!done) @(posedge clk);
        // A second start once done must be ignored
        repeat (3) @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        repeat (10) @(posedge clk);
    endtask

    initial begin
        load_program();
        run_program(MAX_WARPS);
        run_program(2);
        $display("Writes checked: %0d, errors: %0d", writes_checked, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/tb_memory.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_memory import simt_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  instr_t               program_image [2**PC_W],
    input  logic [MAX_WARPS-1:0] imem_valid,
    input  pc_t                  imem_address [MAX_WARPS],
    output logic [MAX_WARPS-1:0] imem_ready,
    output instr_t               imem_data [MAX_WARPS],
    input  port_mask_t           dmem_write_valid,
    output port_mask_t           dmem_write_ready
);

    localparam logic [15:0] SEED = 16'd49597;

    logic [15:0] lfsr;
    logic [1:0]  wait_cnt [MAX_WARPS];

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    initial begin
        lfsr             = SEED;
        imem_ready       = '0;
        dmem_write_ready = '0;
        for (int w = 0; w < MAX_WARPS; w++) begin
            imem_data[w] = '0;
            wait_cnt[w]  = '0;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            imem_ready       <= '0;
            dmem_write_ready <= '0;
        end else begin
            for (int w = 0; w < MAX_WARPS; w++) begin
                if (!imem_valid[w] || imem_ready[w]) begin
                    // Idle or just accepted, so draw the next latency
                    imem_ready[w] <= 1'b0;
                    lfsr = lfsr_next(lfsr);
                    wait_cnt[w][0] <= lfsr[0];
                    lfsr = lfsr_next(lfsr);
                    wait_cnt[w][1] <= lfsr[0];
                end else if (wait_cnt[w] == 2'd0) begin
                    imem_data[w]  <= program_image[imem_address[w]];
                    imem_ready[w] <= 1'b1;
                end else begin
                    wait_cnt[w] <= wait_cnt[w] - 2'd1;
                end
            end
            // Ready is a coin toss each cycle a write is pending
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (dmem_write_valid[p]) begin
                    lfsr = lfsr_next(lfsr);
                    dmem_write_ready[p] <= lfsr[0];
                end else begin
                    dmem_write_ready[p] <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
hdl/simt_pkg.sv
hdl/warp_fetcher.sv
hdl/instr_decoder.sv
hdl/warp_scheduler.sv
hdl/reg_bank.sv
hdl/lane_alu.sv
hdl/store_unit.sv
hdl/compute_core.sv
tb/tb_memory.sv
tb/core_tb.sv
